/* vlog.f */
verilog/shooter_pkg.sv
verilog/game_config_regs.sv
verilog/ship_movement.sv
verilog/missile_movement.sv
verilog/missile_hit_detect.sv
verilog/shooter_top.sv
sim/clock_gen.sv
sim/shooter_assertions.sv
sim/shooter_tb.sv

/* Makefile */
# Verilator build and run for the shooter testbench
# Any variable can be overridden on the command line, e.g. make run TOP=shooter_tb

VERILATOR ?= verilator
TOP       ?= shooter_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_TEXT ?= sim passed

# Sources are every line of the file list that is not a compiler option
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The output is shown and then searched for the pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/shooter_patterns.txt */
# frames left right shoot wr_en wr_addr wr_data(hex) exp_ship_x exp_missile_x exp_missile_y exp_active exp_hits
# A line is repeated for its frame count and its expected values are checked after the last frame
1   0 0 0 0 0 0000 304 0  0   0 0
1   0 1 0 0 0 0000 308 0  0   0 0
1   1 0 0 0 0 0000 304 0  0   0 0
1   1 1 0 0 0 0000 304 0  0   0 0
80  0 1 0 0 0 0000 608 0  0   0 0
1   1 0 0 0 0 0000 604 0  0   0 0
160 1 0 0 0 0 0000 0   0  0   0 0
1   0 1 1 0 0 0000 4   0  0   0 0
1   0 1 0 0 0 0000 8   18 432 1 0
1   0 0 0 0 0 0000 8   18 428 1 0
5   0 0 0 0 0 0000 8   18 408 1 0
1   0 0 0 1 2 0001 8   18 400 1 0
10  0 0 0 0 0 0000 8   18 320 1 0
40  0 0 0 0 0 0000 8   18 0   1 0
1   0 0 0 0 0 0000 8   0  0   0 0
1   0 0 1 1 2 0000 8   0  0   0 0
1   0 1 0 0 0 0000 12  22 432 1 0
3   0 0 0 0 0 0000 12  22 420 1 0
1   0 1 1 0 0 0000 16  22 416 1 0
1   0 0 0 0 0 0000 16  30 432 1 0
1   0 0 0 1 0 0010 16  30 428 1 0
1   0 0 0 1 1 0180 16  30 424 1 0
6   0 0 0 0 0 0000 16  30 400 1 0
1   0 0 0 0 0 0000 16  0  0   0 1
1   0 0 0 1 3 0055 16  0  0   0 1

/* sim/shooter_tb.sv */
`timescale 1ns/1ps

module shooter_tb;

    import shooter_pkg::*;

    localparam string PATTERN_FILE = "sim/shooter_patterns.txt";
    localparam int CYCLES_PER_FRAME = 8;
    localparam int TIMEOUT_MARGIN = 50;
    localparam int DRIVE_DELAY = 1;

    // A pattern line is applied for a number of frames and checked after the last
    typedef struct packed {
        int         frames;
        logic       move_left;
        logic       move_right;
        logic       shoot;
        logic       write_en;
        cfg_addr_t  write_addr;
        cfg_data_t  write_data;
        coordinate  ship_x;
        coordinate  missile_x;
        coordinate  missile_y;
        logic       missile_active;
        hit_count_t hit_count;
    } frame_pattern_t;

    logic       clk;
    logic       resetN;
    logic       start_of_frame;
    logic       move_left;
    logic       move_right;
    logic       shooting_pulse;
    logic       cfg_write;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_wdata;
    coordinate  ship_x;
    coordinate  missile_x;
    coordinate  missile_y;
    logic       missile_active;
    hit_count_t hit_count;

    frame_pattern_t patterns[$];
    int total_frames = 0;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    bit load_ok;

    clock_gen u_clock_gen (.clk(clk), .resetN(resetN));

    shooter_top uut (.*);

    // Prints the closing counts and the verdict, then ends the run
    task automatic finish_run();
        int assertion_failures;
        assertion_failures = uut.u_assertions.failure_count;
        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Lines starting with # are comments and the write data column is hex
    task automatic load_patterns(output bit ok);
        int fd;
        int fields;
        int frames, key_left, key_right, shoot, wen, waddr, wdata;
        int exp_ship, exp_mx, exp_my, exp_active, exp_hits;
        string line;
        frame_pattern_t p;
        ok = 1'b1;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%d %d %d %d %d %d %h %d %d %d %d %d",
                                     frames, key_left, key_right, shoot, wen, waddr, wdata,
                                     exp_ship, exp_mx, exp_my, exp_active, exp_hits);
                    if (fields != 12 || frames < 1) begin
                        $display("pattern line could not be parsed: %s", line);
                        ok = 1'b0;
                    end else begin
                        p.frames         = frames;
                        p.move_left      = key_left[0];
                        p.move_right     = key_right[0];
                        p.shoot          = shoot[0];
                        p.write_en       = wen[0];
                        p.write_addr     = cfg_addr_t'(waddr);
                        p.write_data     = cfg_data_t'(wdata);
                        p.ship_x         = coordinate'(exp_ship);
                        p.missile_x      = coordinate'(exp_mx);
                        p.missile_y      = coordinate'(exp_my);
                        p.missile_active = exp_active[0];
                        p.hit_count      = hit_count_t'(exp_hits);
                        patterns.push_back(p);
                        total_frames += frames;
                    end
                end
            end
            $fclose(fd);
            if (patterns.size() == 0) begin
                $display("the pattern file holds no usable lines");
                ok = 1'b0;
            end
        end
    endtask

    // Moves to the drive point just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_value(input string name, input logic signed [31:0] expected,
                                 input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at time %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs(input frame_pattern_t p);
        compare_value("ship_x", 32'(p.ship_x), 32'(ship_x));
        compare_value("missile_x", 32'(p.missile_x), 32'(missile_x));
        compare_value("missile_y", 32'(p.missile_y), 32'(missile_y));
        compare_value("missile_active", 32'(p.missile_active), 32'(missile_active));
        compare_value("hit_count", 32'(p.hit_count), 32'(hit_count));
    endtask

    // Plays one 8 cycle frame entered at the drive point of cycle 0
    task automatic play_frame(input frame_pattern_t p, input bit check);
        move_left  = p.move_left;
        move_right = p.move_right;
        next_cycle();
        // Cycle 1 holds the optional register write
        cfg_write = p.write_en;
        cfg_addr  = p.write_en ? p.write_addr : '0;
        cfg_wdata = p.write_en ? p.write_data : '0;
        next_cycle();
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        next_cycle();
        // Cycle 3 carries the frame pulse
        start_of_frame = 1'b1;
        next_cycle();
        start_of_frame = 1'b0;
        next_cycle();
        // Cycle 5 carries the shot, which launches on the next frame
        shooting_pulse = p.shoot;
        next_cycle();
        shooting_pulse = 1'b0;
        next_cycle();
        // Cycle 7 sees the collision already cleared
        if (check) begin
            check_outputs(p);
        end
        next_cycle();
    endtask

    initial begin
        start_of_frame = 1'b0;
        move_left      = 1'b0;
        move_right     = 1'b0;
        shooting_pulse = 1'b0;
        cfg_write      = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;
        load_patterns(load_ok);
        if (load_ok) begin
            cycle_limit = total_frames * CYCLES_PER_FRAME + TIMEOUT_MARGIN;
            wait (resetN === 1'b1);
            foreach (patterns[i]) begin
                for (int n = 1; n <= patterns[i].frames; n++) begin
                    play_frame(patterns[i], n == patterns[i].frames);
                end
            end
        end else begin
            error_count++;
        end
        finish_run();
    end

    // Watchdog sized from the number of frames in the pattern file
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the frames did not finish in time", cycle_count);
        error_count++;
        finish_run();
    end

endmodule

/* sim/shooter_assertions.sv */
`timescale 1ns/1ps

module shooter_assertions (
    input logic                    clk,
    input logic                    resetN,
    input logic                    collision,
    input logic                    missile_active,
    input shooter_pkg::hit_count_t hit_count,
    input shooter_pkg::coordinate  ship_x
);

    import shooter_pkg::*;

    localparam coordinate SHIP_MAX_X = SCREEN_W - SHIP_W;

    // Number of assertion failures so far
    int failure_count = 0;

    // The detector masks itself while the missile is being cleared
    collision_one_cycle: assert property (
        @(posedge clk) disable iff (!resetN) collision |=> !collision
    ) else begin
        failure_count++;
        $error("collision stayed high for more than one cycle");
    end

    // The missile is retired on the edge after the collision pulse
    missile_cleared: assert property (
        @(posedge clk) disable iff (!resetN) collision |=> !missile_active
    ) else begin
        failure_count++;
        $error("missile still active in the cycle after collision");
    end

    // The saturating counter may hold but never go back
    hits_never_drop: assert property (
        @(posedge clk) disable iff (!resetN) hit_count >= $past(hit_count)
    ) else begin
        failure_count++;
        $error("hit_count decreased");
    end

    // Clamping keeps the whole ship on screen
    ship_on_screen: assert property (
        @(posedge clk) disable iff (!resetN) (ship_x >= 11'sd0) && (ship_x <= SHIP_MAX_X)
    ) else begin
        failure_count++;
        $error("ship_x left the screen");
    end

endmodule

bind shooter_top shooter_assertions u_assertions (
    .clk            (clk),
    .resetN         (resetN),
    .collision      (collision),
    .missile_active (missile_active),
    .hit_count      (hit_count),
    .ship_x         (ship_x)
);

/* sim/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic resetN
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 10;

    // Free running 100 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released just after a rising edge, like any other stimulus
    initial begin
        resetN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 resetN = 1'b1;
    end

endmodule

/* verilog/shooter_top.sv */
`timescale 1ns/1ps

module shooter_top (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    start_of_frame,
    input  logic                    move_left,
    input  logic                    move_right,
    input  logic                    shooting_pulse,
    input  logic                    cfg_write,
    input  shooter_pkg::cfg_addr_t  cfg_addr,
    input  shooter_pkg::cfg_data_t  cfg_wdata,
    output shooter_pkg::coordinate  ship_x,
    output shooter_pkg::coordinate  missile_x,
    output shooter_pkg::coordinate  missile_y,
    output logic                    missile_active,
    output shooter_pkg::hit_count_t hit_count
);

    import shooter_pkg::*;

    // Target position and speed mode from the host
    game_cfg_t cfg;
    // Retire pulse from the detector back to the missile
    logic collision;

    game_config_regs u_cfg_regs (
        .clk       (clk),
        .resetN    (resetN),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    ship_movement u_ship (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .move_left      (move_left),
        .move_right     (move_right),
        .ship_x         (ship_x)
    );

    missile_movement u_missile (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .shooting_pulse (shooting_pulse),
        .collision      (collision),
        .ship_x         (ship_x),
        .cfg            (cfg),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active)
    );

    missile_hit_detect u_hit_detect (
        .clk            (clk),
        .resetN         (resetN),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active),
        .cfg            (cfg),
        .collision      (collision),
        .hit_count      (hit_count)
    );

endmodule

/* verilog/missile_hit_detect.sv */
`timescale 1ns/1ps

module missile_hit_detect (
    input  logic                    clk,
    input  logic                    resetN,
    input  shooter_pkg::coordinate  missile_x,
    input  shooter_pkg::coordinate  missile_y,
    input  logic                    missile_active,
    input  shooter_pkg::game_cfg_t  cfg,
    output logic                    collision,
    output shooter_pkg::hit_count_t hit_count
);

    import shooter_pkg::*;

    // Box edges one bit wider so a target written near the top of the
    // coordinate range cannot wrap when its size is added
    logic signed [11:0] missile_left;
    logic signed [11:0] missile_right;
    logic signed [11:0] missile_top;
    logic signed [11:0] missile_bottom;
    logic signed [11:0] target_left;
    logic signed [11:0] target_right;
    logic signed [11:0] target_top;
    logic signed [11:0] target_bottom;

    logic target_hit;
    logic top_exit;

    always_comb begin
        missile_left   = 12'(missile_x);
        missile_right  = 12'(missile_x) + 12'(MISSILE_W);
        missile_top    = 12'(missile_y);
        missile_bottom = 12'(missile_y) + 12'(MISSILE_H);
        target_left    = 12'(cfg.target_x);
        target_right   = 12'(cfg.target_x) + 12'(TARGET_W);
        target_top     = 12'(cfg.target_y);
        target_bottom  = 12'(cfg.target_y) + 12'(TARGET_H);
    end

    // Half-open boxes overlap when each starts before the other ends
    assign target_hit = missile_active
                        && (missile_left < target_right) && (target_left < missile_right)
                        && (missile_top < target_bottom) && (target_top < missile_bottom);

    // Any part above row 0 counts as having left the screen
    assign top_exit = missile_active && (missile_y < 11'sd0);

    // The missile stays active for one cycle after the pulse while it is
    // being cleared, so the pulse itself masks a second detection
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            collision <= 1'b0;
            hit_count <= '0;
        end else begin
            collision <= (target_hit || top_exit) && !collision;
            // Only real hits score, and the count holds at its maximum
            if (target_hit && !collision && (hit_count != 8'hFF)) begin
                hit_count <= hit_count + 8'd1;
            end
        end
    end

endmodule

/* verilog/missile_movement.sv */
`timescale 1ns/1ps

module missile_movement (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   start_of_frame,
    input  logic                   shooting_pulse,
    input  logic                   collision,
    input  shooter_pkg::coordinate ship_x,
    input  shooter_pkg::game_cfg_t cfg,
    output shooter_pkg::coordinate missile_x,
    output shooter_pkg::coordinate missile_y,
    output logic                   missile_active
);

    import shooter_pkg::*;

    // The ship's row is fixed, so the launch row is too
    localparam fixed_point LAUNCH_Y =
        fixed_point'(SHIP_Y + MISSILE_Y_OFFSET) * FIXED_POINT_MULTIPLIER;

    // Sub-pixel position of the missile's top left corner
    fixed_point pos_x;
    fixed_point pos_y;
    // A shot was requested during the current frame
    logic shot_pending;

    // Launch column at the ship's nose, scaled to fixed point
    fixed_point launch_x;
    // Vertical step for this frame
    fixed_point step_y;

    always_comb begin
        launch_x = fixed_point'(ship_x + MISSILE_X_OFFSET) * FIXED_POINT_MULTIPLIER;
        // Double speed is a single left shift of the base speed
        step_y = cfg.double_y_speed ? (MISSILE_Y_SPEED <<< 1) : MISSILE_Y_SPEED;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pos_x          <= '0;
            pos_y          <= '0;
            shot_pending   <= 1'b0;
            missile_active <= 1'b0;
        end else begin
            // Retire the missile after a hit or an exit off the top
            if (collision) begin
                pos_x          <= '0;
                pos_y          <= '0;
                missile_active <= 1'b0;
            end

            if (start_of_frame) begin
                shot_pending <= 1'b0;
                if (shot_pending) begin
                    // A shot from the last frame restarts the missile even in flight
                    pos_x          <= launch_x;
                    pos_y          <= LAUNCH_Y;
                    missile_active <= 1'b1;
                end else if (missile_active) begin
                    pos_x <= pos_x + MISSILE_X_SPEED;
                    pos_y <= pos_y + step_y;
                end
            end

            // Placed after the frame branch so a shot on the frame pulse
            // wins over the clear and waits for the next frame
            if (shooting_pulse) begin
                shot_pending <= 1'b1;
            end
        end
    end

    // Back to whole pixels for the rest of the game
    assign missile_x = coordinate'(pos_x / FIXED_POINT_MULTIPLIER);
    assign missile_y = coordinate'(pos_y / FIXED_POINT_MULTIPLIER);

endmodule

/* verilog/ship_movement.sv */
`timescale 1ns/1ps

module ship_movement (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   start_of_frame,
    input  logic                   move_left,
    input  logic                   move_right,
    output shooter_pkg::coordinate ship_x
);

    import shooter_pkg::*;

    // Rightmost legal left edge so the whole ship stays on screen
    localparam coordinate SHIP_MAX_X = SCREEN_W - SHIP_W;

    // Position after this frame's step, before clamping
    coordinate stepped_x;
    // Position after clamping to the screen
    coordinate next_x;

    // Only one key held gives motion
    // Both keys or no key cancel out and the ship stays put
    always_comb begin
        stepped_x = ship_x;
        if (move_left && !move_right) begin
            stepped_x = ship_x - SHIP_SPEED;
        end else if (move_right && !move_left) begin
            stepped_x = ship_x + SHIP_SPEED;
        end
    end

    // The step never exceeds the margin of the 11-bit range,
    // so the compare on the stepped value is safe
    always_comb begin
        if (stepped_x < 11'sd0) begin
            next_x = 11'sd0;
        end else if (stepped_x > SHIP_MAX_X) begin
            next_x = SHIP_MAX_X;
        end else begin
            next_x = stepped_x;
        end
    end

    // The ship moves once per video frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ship_x <= SHIP_START_X;
        end else if (start_of_frame) begin
            ship_x <= next_x;
        end
    end

endmodule

/* verilog/game_config_regs.sv */
`timescale 1ns/1ps

module game_config_regs (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  cfg_write,
    input  shooter_pkg::cfg_addr_t cfg_addr,
    input  shooter_pkg::cfg_data_t cfg_wdata,
    output shooter_pkg::game_cfg_t cfg
);

    import shooter_pkg::*;

    // One register per field, gathered into the struct below
    coordinate target_x;
    coordinate target_y;
    logic      double_y_speed;

    // Fields load from the low data bits on a write strobe
    // An address outside the map leaves every field unchanged
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            target_x       <= CFG_RESET_TARGET_X;
            target_y       <= CFG_RESET_TARGET_Y;
            double_y_speed <= 1'b0;
        end else if (cfg_write) begin
            case (cfg_addr)
                CFG_TARGET_X: begin
                    target_x <= coordinate'(cfg_wdata[10:0]);
                end
                CFG_TARGET_Y: begin
                    target_y <= coordinate'(cfg_wdata[10:0]);
                end
                CFG_CONTROL: begin
                    // Bit 0 doubles the vertical missile speed
                    double_y_speed <= cfg_wdata[0];
                end
                default: begin
                    // An unmapped address drops the write
                end
            endcase
        end
    end

    // The struct is a plain view of the three registers
    always_comb begin
        cfg.target_x       = target_x;
        cfg.target_y       = target_y;
        cfg.double_y_speed = double_y_speed;
    end

endmodule

/* verilog/shooter_pkg.sv */
package shooter_pkg;

    // Signed screen position in pixels so objects can sit partly off screen
    typedef logic signed [10:0] coordinate;
    // Position scaled by 64 to give sub-pixel motion
    typedef logic signed [16:0] fixed_point;
    // Saturating count of missiles that struck the target
    typedef logic [7:0] hit_count_t;
    // Configuration bus address and write data
    typedef logic [1:0] cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Fields written by the host through the register block
    typedef struct packed {
        coordinate target_x;
        coordinate target_y;
        logic      double_y_speed;
    } game_cfg_t;

    localparam fixed_point FIXED_POINT_MULTIPLIER = 17'sd64;

    // Screen and ship geometry
    localparam coordinate SCREEN_W = 11'sd640;
    localparam coordinate SHIP_Y = 11'sd440;
    localparam coordinate SHIP_W = 11'sd32;
    localparam coordinate SHIP_SPEED = 11'sd4;
    localparam coordinate SHIP_START_X = 11'sd304;

    // Missile geometry in pixels and speeds in fixed point per frame
    localparam coordinate MISSILE_X_OFFSET = 11'sd14;
    localparam coordinate MISSILE_Y_OFFSET = -11'sd8;
    localparam coordinate MISSILE_W = 11'sd4;
    localparam coordinate MISSILE_H = 11'sd8;
    localparam fixed_point MISSILE_X_SPEED = 17'sd0;
    localparam fixed_point MISSILE_Y_SPEED = -17'sd256;

    // Target box size
    localparam coordinate TARGET_W = 11'sd32;
    localparam coordinate TARGET_H = 11'sd16;

    // Register map and reset values
    localparam cfg_addr_t CFG_TARGET_X = 2'd0;
    localparam cfg_addr_t CFG_TARGET_Y = 2'd1;
    localparam cfg_addr_t CFG_CONTROL = 2'd2;
    localparam coordinate CFG_RESET_TARGET_X = 11'sd304;
    localparam coordinate CFG_RESET_TARGET_Y = 11'sd40;

endpackage
